// File: icache_pkg.sv
package icache_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int XLEN = 32;  // fetch and memory address width in bits.
  localparam int ILEN = 32;  // one instruction word.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address slicing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // An address splits from the low end into byte, word, set and tag fields.
  // The byte field spans one instruction word and is fixed here.
  // The word and set fields depend on the WORDS and SETS parameters, so each
  // module sizes them itself and the tag takes whatever bits are left.
  localparam int ILEN_BYTES = ILEN / 8;
  localparam int BYTE_BITS  = $clog2(ILEN_BYTES);

  // A line holds WORDS words packed into one vector.
  // word w of a line sits at bits [w*ILEN +: ILEN], so word 0 is in the
  // lowest bits and belongs to the lowest address of the line.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    INVALID = 1'b0,  // nothing has been refilled into this set yet.
    VALID   = 1'b1
  } line_state_e;

endpackage

// File: icache_line_store.sv
`timescale 1ns/1ps

module icache_line_store
  import icache_pkg::*;
#(
  parameter int SETS  = 8,
  parameter int WORDS = 4,
  localparam int SET_BITS  = $clog2(SETS),
  localparam int WORD_BITS = $clog2(WORDS),
  localparam int TAG_BITS  = XLEN - SET_BITS - WORD_BITS - BYTE_BITS,
  localparam int LINE_BITS = WORDS * ILEN
) (
  input  logic                 global_bus,
  input  logic                 rst_n,

  // read side of port 0.
  input  logic [SET_BITS-1:0]  rd_set_0,
  output logic [TAG_BITS-1:0]  rd_tag_0,
  output line_state_e          rd_state_0,
  output logic [LINE_BITS-1:0] rd_line_0,

  // read side of port 1.
  input  logic [SET_BITS-1:0]  rd_set_1,
  output logic [TAG_BITS-1:0]  rd_tag_1,
  output line_state_e          rd_state_1,
  output logic [LINE_BITS-1:0] rd_line_1,

  // refill write from the arbiter.
  input  logic                 fill_en,
  input  logic [SET_BITS-1:0]  fill_set,
  input  logic [TAG_BITS-1:0]  fill_tag,
  input  logic [LINE_BITS-1:0] fill_line
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // One entry per set, direct mapped.
  logic [TAG_BITS-1:0]  tag_q   [SETS];
  line_state_e          state_q [SETS];
  logic [LINE_BITS-1:0] line_q  [SETS];

  // Only the state needs a known value after reset.
  // a set marked INVALID never hits, whatever its tag and words hold.
  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SETS; s++) begin
        state_q[s] <= INVALID;
      end
    end else if (fill_en) begin
      state_q[fill_set] <= VALID;  // the refilled line becomes readable next cycle.
    end
  end

  // A refill replaces the whole line and its tag in one edge.
  always_ff @(posedge global_bus) begin
    if (fill_en) begin
      tag_q[fill_set]  <= fill_tag;
      line_q[fill_set] <= fill_line;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Both reads are combinational so a hit answers in the cycle of the read.
  // they are independent and may address the same set.
  assign rd_tag_0   = tag_q[rd_set_0];
  assign rd_state_0 = state_q[rd_set_0];
  assign rd_line_0  = line_q[rd_set_0];

  assign rd_tag_1   = tag_q[rd_set_1];
  assign rd_state_1 = state_q[rd_set_1];
  assign rd_line_1  = line_q[rd_set_1];

endmodule

// File: icache_lookup_port.sv
`timescale 1ns/1ps

module icache_lookup_port
  import icache_pkg::*;
#(
  parameter int SETS  = 8,
  parameter int WORDS = 4,
  localparam int SET_BITS  = $clog2(SETS),
  localparam int WORD_BITS = $clog2(WORDS),
  localparam int TAG_BITS  = XLEN - SET_BITS - WORD_BITS - BYTE_BITS,
  localparam int LINE_BITS = WORDS * ILEN
) (
  input  logic                 global_bus,
  input  logic                 rst_n,

  // fetch side.
  input  logic                 read,
  input  logic [XLEN-1:0]      address,
  output logic [ILEN-1:0]      instr,
  output logic                 hit,

  // line store read.
  output logic [SET_BITS-1:0]  rd_set,
  input  logic [TAG_BITS-1:0]  rd_tag,
  input  line_state_e          rd_state,
  input  logic [LINE_BITS-1:0] rd_line,

  // miss request to the arbiter and its answer.
  output logic                 miss_req,
  output logic [XLEN-1:0]      miss_line_addr,
  input  logic                 fill_done,
  input  logic [XLEN-1:0]      fill_line_addr
);

  localparam int OFFSET_BITS = WORD_BITS + BYTE_BITS;  // bits below the set field.

  logic [TAG_BITS-1:0]  tag;
  logic [WORD_BITS-1:0] word;
  logic [XLEN-1:0]      line_addr;
  logic                 tag_match;
  logic                 fill_seen_q;

  assign tag       = address[XLEN-1 -: TAG_BITS];
  assign rd_set    = address[OFFSET_BITS +: SET_BITS];
  assign word      = address[BYTE_BITS +: WORD_BITS];
  assign line_addr = {address[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  // A valid line with our tag answers in the same cycle.
  assign tag_match = (rd_state == VALID) && (rd_tag == tag);
  assign hit       = read && tag_match;
  assign instr     = hit ? rd_line[word*ILEN +: ILEN] : '0;

  // Remembers that our line was refilled for the read in progress.
  // The refill lands at the edge after fill_done, and this flag keeps the
  // request down until the port sees its hit. It clears with the hit or
  // when read falls, so the next access starts clean.
  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      fill_seen_q <= 1'b0;
    end else if (!read || hit) begin
      fill_seen_q <= 1'b0;
    end else if (fill_done && (fill_line_addr == line_addr)) begin
      fill_seen_q <= 1'b1;
    end
  end

  assign miss_req       = read && !tag_match && !fill_seen_q;
  assign miss_line_addr = line_addr;  // always line aligned.

endmodule

// File: icache_refill_arbiter.sv
`timescale 1ns/1ps

module icache_refill_arbiter
  import icache_pkg::*;
#(
  parameter int SETS  = 8,
  parameter int WORDS = 4,
  localparam int SET_BITS  = $clog2(SETS),
  localparam int WORD_BITS = $clog2(WORDS),
  localparam int TAG_BITS  = XLEN - SET_BITS - WORD_BITS - BYTE_BITS,
  localparam int LINE_BITS = WORDS * ILEN
) (
  input  logic                 global_bus,
  input  logic                 rst_n,

  // miss requests from the two lookup ports.
  input  logic                 miss_req_0,
  input  logic [XLEN-1:0]      miss_line_addr_0,
  input  logic                 miss_req_1,
  input  logic [XLEN-1:0]      miss_line_addr_1,

  // memory read bus.
  output logic                 mem_read,
  output logic [XLEN-1:0]      mem_address,
  input  logic                 mem_ready,
  input  logic [LINE_BITS-1:0] mem_line,

  // refill write into the line store.
  output logic                 fill_en,
  output logic [SET_BITS-1:0]  fill_set,
  output logic [TAG_BITS-1:0]  fill_tag,
  output logic [LINE_BITS-1:0] fill_line,

  // completion back to the lookup ports.
  output logic                 fill_done,
  output logic [XLEN-1:0]      fill_line_addr
);

  localparam int OFFSET_BITS = WORD_BITS + BYTE_BITS;

  typedef enum logic {
    ARB_IDLE = 1'b0,
    ARB_BUSY = 1'b1
  } arb_state_e;

  arb_state_e      state_q;
  logic            last_grant_q;  // port served by the most recent refill.
  logic            any_req;
  logic            grant;         // port picked in this idle cycle.
  logic [XLEN-1:0] addr_q;        // line address of the refill in flight.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // grant selection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign any_req = miss_req_0 || miss_req_1;

  // With both ports waiting the one not served last goes first.
  // A lone request is simply taken.
  always_comb begin
    if (miss_req_0 && miss_req_1) begin
      grant = ~last_grant_q;
    end else begin
      grant = miss_req_1;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // refill FSM
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // last_grant_q starts at port 1 so port 0 wins the first conflict.
  always_ff @(posedge global_bus or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= ARB_IDLE;
      last_grant_q <= 1'b1;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (any_req) begin
            state_q      <= ARB_BUSY;
            last_grant_q <= grant;
          end
        end
        ARB_BUSY: begin
          if (mem_ready) begin
            state_q <= ARB_IDLE;  // mem_read falls in the next cycle.
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // The address is only captured on a grant and stays put while busy.
  always_ff @(posedge global_bus) begin
    if ((state_q == ARB_IDLE) && any_req) begin
      addr_q <= grant ? miss_line_addr_1 : miss_line_addr_0;
    end
  end

  assign mem_read    = (state_q == ARB_BUSY);
  assign mem_address = addr_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // refill write and completion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // The line is written at the edge that ends the mem_ready cycle.
  assign fill_en   = mem_read && mem_ready;
  assign fill_set  = addr_q[OFFSET_BITS +: SET_BITS];
  assign fill_tag  = addr_q[XLEN-1 -: TAG_BITS];
  assign fill_line = mem_line;

  // Every port waiting on this line sees the same pulse, so a line both
  // ports missed on is fetched only once.
  assign fill_done      = fill_en;
  assign fill_line_addr = addr_q;

endmodule

// File: dual_port_icache.sv
`timescale 1ns/1ps

module dual_port_icache
  import icache_pkg::*;
#(
  parameter int SETS  = 8,
  parameter int WORDS = 4,
  localparam int SET_BITS  = $clog2(SETS),
  localparam int WORD_BITS = $clog2(WORDS),
  localparam int TAG_BITS  = XLEN - SET_BITS - WORD_BITS - BYTE_BITS,
  localparam int LINE_BITS = WORDS * ILEN
) (
  input  logic                 global_bus,
  input  logic                 rst_n,

  // fetch port 0.
  input  logic                 read_0,
  input  logic [XLEN-1:0]      address_0,
  output logic [ILEN-1:0]      instr_0,
  output logic                 hit_0,

  // fetch port 1.
  input  logic                 read_1,
  input  logic [XLEN-1:0]      address_1,
  output logic [ILEN-1:0]      instr_1,
  output logic                 hit_1,

  // memory read bus.
  output logic                 mem_read,
  output logic [XLEN-1:0]      mem_address,
  input  logic                 mem_ready,
  input  logic [LINE_BITS-1:0] mem_line
);

  // line store reads, one set per port.
  logic [SET_BITS-1:0]  rd_set_0;
  logic [TAG_BITS-1:0]  rd_tag_0;
  line_state_e          rd_state_0;
  logic [LINE_BITS-1:0] rd_line_0;
  logic [SET_BITS-1:0]  rd_set_1;
  logic [TAG_BITS-1:0]  rd_tag_1;
  line_state_e          rd_state_1;
  logic [LINE_BITS-1:0] rd_line_1;

  // misses toward the arbiter.
  logic                 miss_req_0;
  logic [XLEN-1:0]      miss_line_addr_0;
  logic                 miss_req_1;
  logic [XLEN-1:0]      miss_line_addr_1;

  // refill path.
  logic                 fill_en;
  logic [SET_BITS-1:0]  fill_set;
  logic [TAG_BITS-1:0]  fill_tag;
  logic [LINE_BITS-1:0] fill_line;
  logic                 fill_done;
  logic [XLEN-1:0]      fill_line_addr;

  icache_line_store #(
    .SETS  (SETS),
    .WORDS (WORDS)
  ) u_line_store (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .rd_set_0   (rd_set_0),
    .rd_tag_0   (rd_tag_0),
    .rd_state_0 (rd_state_0),
    .rd_line_0  (rd_line_0),
    .rd_set_1   (rd_set_1),
    .rd_tag_1   (rd_tag_1),
    .rd_state_1 (rd_state_1),
    .rd_line_1  (rd_line_1),
    .fill_en    (fill_en),
    .fill_set   (fill_set),
    .fill_tag   (fill_tag),
    .fill_line  (fill_line)
  );

  icache_lookup_port #(
    .SETS  (SETS),
    .WORDS (WORDS)
  ) u_lookup_port_0 (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .read           (read_0),
    .address        (address_0),
    .instr          (instr_0),
    .hit            (hit_0),
    .rd_set         (rd_set_0),
    .rd_tag         (rd_tag_0),
    .rd_state       (rd_state_0),
    .rd_line        (rd_line_0),
    .miss_req       (miss_req_0),
    .miss_line_addr (miss_line_addr_0),
    .fill_done      (fill_done),
    .fill_line_addr (fill_line_addr)
  );

  icache_lookup_port #(
    .SETS  (SETS),
    .WORDS (WORDS)
  ) u_lookup_port_1 (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .read           (read_1),
    .address        (address_1),
    .instr          (instr_1),
    .hit            (hit_1),
    .rd_set         (rd_set_1),
    .rd_tag         (rd_tag_1),
    .rd_state       (rd_state_1),
    .rd_line        (rd_line_1),
    .miss_req       (miss_req_1),
    .miss_line_addr (miss_line_addr_1),
    .fill_done      (fill_done),
    .fill_line_addr (fill_line_addr)
  );

  icache_refill_arbiter #(
    .SETS  (SETS),
    .WORDS (WORDS)
  ) u_refill_arbiter (
    .global_bus       (global_bus),
    .rst_n            (rst_n),
    .miss_req_0       (miss_req_0),
    .miss_line_addr_0 (miss_line_addr_0),
    .miss_req_1       (miss_req_1),
    .miss_line_addr_1 (miss_line_addr_1),
    .mem_read         (mem_read),
    .mem_address      (mem_address),
    .mem_ready        (mem_ready),
    .mem_line         (mem_line),
    .fill_en          (fill_en),
    .fill_set         (fill_set),
    .fill_tag         (fill_tag),
    .fill_line        (fill_line),
    .fill_done        (fill_done),
    .fill_line_addr   (fill_line_addr)
  );

endmodule

// File: icache_assert.sv
`timescale 1ns/1ps

module icache_assert
  import icache_pkg::*;
(
  input logic            global_bus,
  input logic            rst_n,
  input logic            mem_read,
  input logic [XLEN-1:0] mem_address,
  input logic            mem_ready,
  input logic            fill_en
);

  // a request stays up until memory answers it.
  assert property (@(posedge global_bus) disable iff (!rst_n)
    mem_read && !mem_ready |=> mem_read)
    else $error("mem_read dropped before mem_ready");

  assert property (@(posedge global_bus) disable iff (!rst_n)
    mem_read && !mem_ready |=> $stable(mem_address))
    else $error("mem_address changed while mem_read was high");

  // the refill write ends the request, so mem_read is down in the next cycle.
  assert property (@(posedge global_bus) disable iff (!rst_n)
    fill_en |=> !mem_read)
    else $error("mem_read still high after the refill write");

endmodule

bind icache_refill_arbiter icache_assert u_icache_assert (
  .global_bus  (global_bus),
  .rst_n       (rst_n),
  .mem_read    (mem_read),
  .mem_address (mem_address),
  .mem_ready   (mem_ready),
  .fill_en     (fill_en)
);

// File: tb_dual_port_icache.sv
`timescale 1ns/1ps

module tb_dual_port_icache
  import icache_pkg::*;
();

  localparam int SETS           = 8;
  localparam int WORDS          = 4;
  localparam int LINE_BITS      = WORDS * ILEN;
  localparam int LINE_BYTES     = WORDS * ILEN_BYTES;
  localparam int TIMEOUT_CYCLES = 50;
  localparam logic [ILEN-1:0] MEM_PATTERN = 32'hA5A50000;  // memory word = byte address ^ this.

  logic                 global_bus = 1'b0;
  logic                 rst_n;
  logic                 read_0;
  logic [XLEN-1:0]      address_0;
  logic [ILEN-1:0]      instr_0;
  logic                 hit_0;
  logic                 read_1;
  logic [XLEN-1:0]      address_1;
  logic [ILEN-1:0]      instr_1;
  logic                 hit_1;
  logic                 mem_read;
  logic [XLEN-1:0]      mem_address;
  logic                 mem_ready;
  logic [LINE_BITS-1:0] mem_line;

  int              mem_reads   = 0;     // memory reads seen since reset.
  int              next_refill = 0;     // index of the next memory read still due.
  logic [XLEN-1:0] refill_lines[$];     // lines the cache has to read, in grant order.
  logic [XLEN-1:0] model_line  [SETS];  // line each set holds after its last refill.
  logic            model_valid [SETS];
  logic            last_port   = 1'b1;  // port 0 wins the first conflict.

  always #4 global_bus = ~global_bus;

  dual_port_icache #(
    .SETS  (SETS),
    .WORDS (WORDS)
  ) u_dual_port_icache (
    .global_bus  (global_bus),
    .rst_n       (rst_n),
    .read_0      (read_0),
    .address_0   (address_0),
    .instr_0     (instr_0),
    .hit_0       (hit_0),
    .read_1      (read_1),
    .address_1   (address_1),
    .instr_1     (instr_1),
    .hit_1       (hit_1),
    .mem_read    (mem_read),
    .mem_address (mem_address),
    .mem_ready   (mem_ready),
    .mem_line    (mem_line)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers and compare tasks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [XLEN-1:0] line_of(input logic [XLEN-1:0] a);
    return a - (a % LINE_BYTES);
  endfunction

  function automatic int set_of(input logic [XLEN-1:0] a);
    return int'((a / LINE_BYTES) % SETS);
  endfunction

  // true when the line of a already sits in its set.
  function automatic logic is_cached(input logic [XLEN-1:0] a);
    return model_valid[set_of(a)] && (model_line[set_of(a)] == line_of(a));
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_instr(input string name, input logic [ILEN-1:0] exp,
                             input logic [ILEN-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_hit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_mem_address(input string name, input logic [XLEN-1:0] exp,
                                   input logic [XLEN-1:0] act);
    if (act !== exp) begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_reads(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("MISMATCH %s expected 0x%h actual 0x%h", name, exp, act);
      stop_with_failure();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // cache model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // A refill reads the whole line and replaces whatever its set held.
  task automatic add_refill(input logic [XLEN-1:0] a);
    refill_lines.push_back(line_of(a));
    model_line[set_of(a)]  = line_of(a);
    model_valid[set_of(a)] = 1'b1;
  endtask

  // Queues the memory reads one operation must cause, in grant order.
  task automatic queue_refills(input int mode, input logic [XLEN-1:0] a0,
                               input logic [XLEN-1:0] a1);
    logic miss_0;
    logic miss_1;
    logic first;
    miss_0 = (mode != 1) && !is_cached(a0);
    miss_1 = (mode != 0) && !is_cached(a1);
    first  = !last_port;
    if (miss_0 && miss_1 && (line_of(a0) == line_of(a1))) begin
      add_refill(a0);  // one read answers both ports.
      last_port = first;
    end else if (miss_0 && miss_1) begin
      add_refill(first ? a1 : a0);
      add_refill(first ? a0 : a1);
      last_port = !first;
    end else if (miss_0 || miss_1) begin
      add_refill(miss_1 ? a1 : a0);
      last_port = miss_1;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Answers each request after 1 to 4 cycles with a one-cycle mem_ready pulse.
  initial begin : memory_model
    int latency;
    mem_ready = 1'b0;
    mem_line  = '0;
    void'($urandom(29985));
    forever begin
      @(posedge global_bus);
      #1;
      if (rst_n && mem_read) begin
        mem_reads++;
        if (next_refill >= refill_lines.size()) begin
          $display("memory read of 0x%h while no refill was due", mem_address);
          stop_with_failure();
        end else begin
          check_mem_address("mem_address", refill_lines[next_refill], mem_address);
          next_refill++;
        end
        latency = 1 + int'($urandom % 4);
        repeat (latency) @(posedge global_bus);
        #1;
        for (int w = 0; w < WORDS; w++) begin
          mem_line[w*ILEN +: ILEN] = (mem_address + XLEN'(w * ILEN_BYTES)) ^ MEM_PATTERN;
        end
        mem_ready = 1'b1;
        @(posedge global_bus);
        #1;
        mem_ready = 1'b0;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // mode 0 drives port 0, mode 1 drives port 1 and mode 2 drives both.
  task automatic run_op(input int mode, input logic [XLEN-1:0] a0, input logic [ILEN-1:0] e0,
                        input logic [XLEN-1:0] a1, input logic [ILEN-1:0] e1, input int reads);
    int   start;
    int   cycles;
    logic done_0;
    logic done_1;
    start  = mem_reads;
    done_0 = (mode == 1);
    done_1 = (mode == 0);
    queue_refills(mode, a0, a1);
    @(posedge global_bus);
    #1;
    read_0    = !done_0;
    address_0 = a0;
    read_1    = !done_1;
    address_1 = a1;
    cycles    = 0;
    while (!(done_0 && done_1)) begin
      @(negedge global_bus);  // outputs are settled mid cycle.
      if (!done_0 && hit_0) begin
        check_instr("instr_0", e0, instr_0);
        done_0 = 1'b1;
      end else if (!done_0) begin
        check_instr("instr_0", '0, instr_0);  // a miss hands out no word.
      end
      if (!done_1 && hit_1) begin
        check_instr("instr_1", e1, instr_1);
        done_1 = 1'b1;
      end else if (!done_1) begin
        check_instr("instr_1", '0, instr_1);
      end
      cycles++;
      if (!(done_0 && done_1) && cycles >= TIMEOUT_CYCLES) begin
        if (!done_0) begin
          $display("port 0 never hit on address 0x%h within %0d cycles", a0, cycles);
        end else begin
          $display("port 1 never hit on address 0x%h within %0d cycles", a1, cycles);
        end
        stop_with_failure();
      end
      @(posedge global_bus);
      #1;
      if (done_0) read_0 = 1'b0;  // the fetch unit lets go once it sees its hit.
      if (done_1) read_1 = 1'b0;
    end
    check_reads("memory reads", reads, mem_reads - start);
  endtask

  initial begin : main
    int              fd;
    int              cnt;
    int              ops;
    int              mode;
    int              reads;
    logic [XLEN-1:0] a0;
    logic [XLEN-1:0] a1;
    logic [ILEN-1:0] e0;
    logic [ILEN-1:0] e1;
    string           text;
    rst_n      = 1'b0;
    read_0     = 1'b0;
    address_0  = '0;
    read_1     = 1'b0;
    address_1  = '0;
    for (int s = 0; s < SETS; s++) begin
      model_valid[s] = 1'b0;  // every set starts empty after reset.
    end
    repeat (5) @(posedge global_bus);
    #1;
    rst_n = 1'b1;
    @(negedge global_bus);
    check_hit("hit_0", 1'b0, hit_0);
    check_hit("hit_1", 1'b0, hit_1);
    check_hit("mem_read", 1'b0, mem_read);
    fd = $fopen("icache_golden.txt", "r");
    if (fd == 0) begin
      $display("the golden file icache_golden.txt could not be opened");
      stop_with_failure();
    end
    ops = 0;
    while ($fgets(text, fd) != 0) begin
      if (text.len() < 2 || text[0] == "#") continue;
      cnt = $sscanf(text, "%d %h %h %h %h %d", mode, a0, e0, a1, e1, reads);
      if (cnt != 6) begin
        $display("golden operation %0d has %0d fields instead of 6", ops + 1, cnt);
        stop_with_failure();
      end
      run_op(mode, a0, e0, a1, e1, reads);
      ops++;
    end
    $fclose(fd);
    if (ops == 0) begin
      $display("the golden file holds no operations");
      stop_with_failure();
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

// File: icache_golden.txt
# mode addr_0 expect_0 addr_1 expect_1 mem_reads
# mode 0 is port 0, 1 is port 1, 2 is both; addresses and words in hex, mem_reads decimal
0 00000104 a5a50104 00000000 00000000 1
1 00000000 00000000 0000010c a5a5010c 0
0 00000108 a5a50108 00000000 00000000 0
2 00000120 a5a50120 00000134 a5a50134 2
2 00000148 a5a50148 0000014c a5a5014c 1
0 00000500 a5a50500 00000000 00000000 1
1 00000000 00000000 00000104 a5a50104 1
0 00000504 a5a50504 00000000 00000000 1
2 00000124 a5a50124 00000138 a5a50138 0
0 00012340 a5a42340 00000000 00000000 1
1 00000000 00000000 0000014c a5a5014c 1
2 00012344 a5a42344 00000150 a5a50150 2
0 00000154 a5a50154 00000000 00000000 0
1 00000000 00000000 00000168 a5a50168 1
1 00000000 00000000 0000017c a5a5017c 1
2 00000160 a5a50160 00000174 a5a50174 0
2 00000200 a5a50200 00000210 a5a50210 2
2 00000204 a5a50204 0000020c a5a5020c 0
0 00000abc a5a50abc 00000000 00000000 1
1 00000000 00000000 00000138 a5a50138 1
2 00000ab0 a5a50ab0 00000ab8 a5a50ab8 1
0 0000fff0 a5a5fff0 00000000 00000000 1
1 00000000 00000000 0000fffc a5a5fffc 0
2 00a50000 a5000000 00000214 a5a50214 1
1 00000000 00000000 00a5000c a500000c 0
2 00000164 a5a50164 00000228 a5a50228 1
0 00000124 a5a50124 00000000 00000000 1
2 00000240 a5a50240 00000254 a5a50254 2
2 00000248 a5a50248 00000258 a5a50258 0
0 00000104 a5a50104 00000000 00000000 1

// File: dual_port_icache.f
icache_pkg.sv
icache_line_store.sv
icache_lookup_port.sv
icache_refill_arbiter.sv
dual_port_icache.sv
icache_assert.sv
tb_dual_port_icache.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_dual_port_icache
FILELIST   ?= dual_port_icache.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
